// ==== fcNeuron.f ====
verilog/fcNeuronPkg.sv
verilog/floatMult.sv
verilog/floatAdder.sv
verilog/neuronRegs.sv
verilog/neuronNode.sv
verilog/fcNeuronTop.sv
testbench/neuronNode_assertions.sv
testbench/fcNeuronTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
rm -f sim.log
verilator --binary --timing --assert --top-module fcNeuronTb -f fcNeuron.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== testbench/fcNeuronTb.sv ====
`timescale 1ns/1ps

module fcNeuronTb;
	import fcNeuronPkg::*;

	localparam int clkPeriod = 4;
	localparam int cmdCycles = 40; // generous bound per command line.
	localparam string dataPath = "testbench/fcNeuronTestdata.txt";

	logic clk;
	logic reset;
	axiLiteReq bus;
	axiLiteResp busResp;
	logic [numInputs-1:0][floatWidth-1:0] activations;
	logic inValid;
	logic [floatWidth-1:0] result;
	logic outValid;

	logic [floatWidth-1:0] expQueue[$];
	time issueQueue[$];
	int errorCount = 0;
	int limitCycles = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int testErrors = 0;
	string testName = "";

	fcNeuronTop i_dut (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.busResp(busResp),
		.activations(activations),
		.inValid(inValid),
		.result(result),
		.outValid(outValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			errorCount++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic busWrite(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input axiResp expResp);
		int delay;
		@(posedge clk);
		bus.awAddr <= addr;
		bus.wData <= data;
		bus.wStrb <= strb;
		bus.awValid <= 1'b1;
		bus.wValid <= 1'b1;
		@(negedge clk);
		while (!busResp.awReady)
			@(negedge clk);
		checkValue("write data ready", 32'(busResp.wReady), 32'd1);
		@(posedge clk);
		bus.awValid <= 1'b0;
		bus.wValid <= 1'b0;
		@(negedge clk);
		while (!busResp.bValid)
			@(negedge clk);
		delay = $urandom_range(3, 0); // back-pressure on the response.
		repeat (delay) @(negedge clk);
		checkValue("write response", 32'(busResp.bResp), 32'(expResp));
		@(posedge clk);
		bus.bReady <= 1'b1;
		@(posedge clk);
		bus.bReady <= 1'b0;
	endtask

	task automatic busRead(input logic [7:0] addr, input logic [31:0] expData,
		input axiResp expResp);
		int delay;
		@(posedge clk);
		bus.arAddr <= addr;
		bus.arValid <= 1'b1;
		@(negedge clk);
		while (!busResp.arReady)
			@(negedge clk);
		@(posedge clk);
		bus.arValid <= 1'b0;
		@(negedge clk);
		while (!busResp.rValid)
			@(negedge clk);
		delay = $urandom_range(3, 0);
		repeat (delay) @(negedge clk);
		checkValue("read data", busResp.rData, expData);
		checkValue("read response", 32'(busResp.rResp), 32'(expResp));
		@(posedge clk);
		bus.rReady <= 1'b1;
		@(posedge clk);
		bus.rReady <= 1'b0;
	endtask

	task automatic sendVector(input logic [numInputs-1:0][floatWidth-1:0] acts,
		input logic [31:0] expected);
		@(posedge clk);
		activations <= acts;
		inValid <= 1'b1;
		expQueue.push_back(expected);
		issueQueue.push_back($time);
	endtask

	task automatic endTest();
		while (expQueue.size() != 0)
			@(negedge clk);
		if (testName != "")
		begin
			if (errorCount == testErrors)
			begin
				testsPassed++;
				$display("test %s: ok", testName);
			end
			else
			begin
				testsFailed++;
				$display("test %s: %0d errors", testName, errorCount - testErrors);
			end
		end
	endtask

	// results settle six edges after the drive edge and are sampled half a cycle later.
	always @(negedge clk)
	begin
		if (!reset && outValid)
		begin
			if (expQueue.size() == 0)
			begin
				errorCount++;
				$display("Unexpected output %h at %0d ns with no vector pending", result, $time);
			end
			else
			begin
				checkValue("result", result, expQueue.pop_front());
				checkValue("latency in ns", 32'($time - issueQueue.pop_front()),
					stageCount * clkPeriod + clkPeriod / 2);
			end
		end
	end

	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("Watchdog expired: the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int fd;
		int lineCount;
		string line;
		logic [7:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [1:0] resp;
		logic [31:0] words [16];
		logic [numInputs-1:0][floatWidth-1:0] acts;
		bit streaming;
		void'($urandom(75));
		reset <= 1'b1;
		bus <= '0;
		activations <= '0;
		inValid <= 1'b0;
		streaming = 1'b0;
		lineCount = 0;
		fd = $fopen(dataPath, "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file %s", dataPath);
			$display("TEST FAILED");
			$finish;
		end
		while (!$feof(fd))
			if ($fgets(line, fd) > 0)
				lineCount++;
		$fclose(fd);
		limitCycles = 20 + lineCount * cmdCycles;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("outValid after reset", 32'(outValid), 32'd0);
		fd = $fopen(dataPath, "r");
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) == 0)
				continue;
			if (line.getc(0) != "V" && streaming)
			begin
				@(posedge clk);
				inValid <= 1'b0;
				streaming = 1'b0;
			end
			case (line.getc(0))
				"T":
				begin
					endTest();
					void'($sscanf(line, "T %s", testName));
					testErrors = errorCount;
				end
				"W":
				begin
					void'($sscanf(line, "W %h %h %h %h", addr, data, strb, resp));
					busWrite(addr, data, strb, axiResp'(resp));
				end
				"R":
				begin
					void'($sscanf(line, "R %h %h %h", addr, data, resp));
					busRead(addr, data, axiResp'(resp));
				end
				"Z":
					for (int i = 0; i < treeLeaves; i++)
						busRead(8'(4 * i), 32'd0, OKAY); // all registers clear after reset.
				"V":
				begin
					void'($sscanf(line, "V %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						words[0], words[1], words[2], words[3], words[4], words[5],
						words[6], words[7], words[8], words[9], words[10], words[11],
						words[12], words[13], words[14], words[15]));
					for (int i = 0; i < numInputs; i++)
						acts[i] = words[i];
					sendVector(acts, words[15]);
					streaming = 1'b1;
				end
				default: ;
			endcase
		end
		$fclose(fd);
		endTest();
		$display("tests passed: %0d, failed: %0d, errors: %0d", testsPassed, testsFailed,
			errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

// ==== testbench/fcNeuronTestdata.txt ====
# T name | W addr data strb resp | R addr data resp | Z reads all registers as zero
# V act0 .. act14 expected, all hex; resp 0 is OKAY, 2 is SLVERR
T reset
Z
T regs
W 00 3f800000 f 0
W 04 40000000 f 0
W 08 40400000 f 0
W 3c 3f800000 f 0
R 00 3f800000 0
R 04 40000000 0
R 3c 3f800000 0
W 08 12345678 2 0
R 08 40405600 0
W 08 40400000 f 0
T slverr
W 40 deadbeef f 2
R 40 00000000 2
R fc 00000000 2
R 00 3f800000 0
R 08 40400000 0
T positive
V 3f800000 3f800000 3f800000 0 0 0 0 0 0 0 0 0 0 0 0 40e00000
V 40000000 3f000000 40400000 41200000 0 0 0 0 0 0 0 0 0 0 0 41500000
T negative
V c1000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
V bf800000 bf800000 bf800000 0 0 0 0 0 0 0 0 0 0 0 0 0
T stream
V 3f800000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40000000
V 40000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40400000
V 40400000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40800000
W 00 40000000 f 0
V 3f800000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40400000
V 40400000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 40e00000
R 00 40000000 0

// ==== testbench/neuronNode_assertions.sv ====
`timescale 1ns/1ps

module neuronNodeAssertions (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  logic outValid,
	input  fcNeuronPkg::axiLiteReq bus,
	input  fcNeuronPkg::axiLiteResp busResp
);
	import fcNeuronPkg::*;

	latency: assert property (@(posedge clk) disable iff (reset)
		outValid == $past(inValid, stageCount))
		else $error("outValid does not follow inValid by the node latency");

	resetClear: assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid high after reset");

	bHold: assert property (@(posedge clk) disable iff (reset)
		busResp.bValid && !bus.bReady |=> busResp.bValid)
		else $error("write response dropped before bReady");

	rHold: assert property (@(posedge clk) disable iff (reset)
		busResp.rValid && !bus.rReady |=> busResp.rValid && $stable(busResp.rData))
		else $error("read data changed or dropped before rReady");
endmodule

// bound at the top so the bus and the node strobes are both in view.
bind fcNeuronTop neuronNodeAssertions checks (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.outValid(outValid),
	.bus(bus),
	.busResp(busResp)
);

// ==== verilog/fcNeuronPkg.sv ====
package fcNeuronPkg;
	localparam int numInputs = 15; // activations and weights per vector.
	localparam int floatWidth = 32;
	localparam int regAddrWidth = 8;
	localparam int treeLeaves = numInputs + 1; // products plus the bias.
	localparam int regIndexWidth = $clog2(treeLeaves);
	localparam int stageCount = 6; // node latency in cycles.
	localparam logic [regAddrWidth-1:0] biasAddr = 8'h3C; // weights sit at 00 to 38.
	localparam logic signed [9:0] floatBias = 10'sd127;
	localparam logic [floatWidth-2:0] maxMagnitude = 31'h7F7FFFFF; // largest finite value.

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axiResp;

	typedef enum logic {
		wrIdle,
		wrResp
	} wrState;

	typedef enum logic {
		rdIdle,
		rdData
	} rdState;

	typedef struct packed {
		logic [regAddrWidth-1:0] awAddr;
		logic awValid;
		logic [floatWidth-1:0] wData;
		logic [floatWidth/8-1:0] wStrb;
		logic wValid;
		logic bReady;
		logic [regAddrWidth-1:0] arAddr;
		logic arValid;
		logic rReady;
	} axiLiteReq;

	typedef struct packed {
		logic awReady;
		logic wReady;
		logic arReady;
		logic bValid;
		axiResp bResp;
		logic [floatWidth-1:0] rData;
		logic rValid;
		axiResp rResp;
	} axiLiteResp;

	typedef struct packed {
		logic [numInputs-1:0][floatWidth-1:0] weights;
		logic [floatWidth-1:0] bias;
	} nodeParams;
endpackage

// ==== verilog/fcNeuronTop.sv ====
`timescale 1ns/1ps

module fcNeuronTop (
	input  logic clk,
	input  logic reset,
	input  fcNeuronPkg::axiLiteReq bus,
	output fcNeuronPkg::axiLiteResp busResp,
	input  logic [fcNeuronPkg::numInputs-1:0][fcNeuronPkg::floatWidth-1:0] activations,
	input  logic inValid,
	output logic [fcNeuronPkg::floatWidth-1:0] result,
	output logic outValid
);
	import fcNeuronPkg::*;

	nodeParams params; // weights and bias, always live.

	neuronRegs regs (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.busResp(busResp),
		.params(params)
	);

	neuronNode node (
		.clk(clk),
		.reset(reset),
		.params(params),
		.activations(activations),
		.inValid(inValid),
		.result(result),
		.outValid(outValid)
	);
endmodule

// ==== verilog/floatAdder.sv ====
`timescale 1ns/1ps

module floatAdder (
	input  logic [fcNeuronPkg::floatWidth-1:0] a,
	input  logic [fcNeuronPkg::floatWidth-1:0] b,
	output logic [fcNeuronPkg::floatWidth-1:0] sum
);
	import fcNeuronPkg::*;

	logic [30:0] aMag;
	logic [30:0] bMag;
	logic swap;
	logic [31:0] bigOp;
	logic [31:0] smallOp;
	logic [7:0] expBig;
	logic [7:0] shiftAmt;
	logic [23:0] mantBig;
	logic [23:0] mantSmall;
	logic [23:0] mantAligned;
	logic subtract;
	logic [24:0] mantSum;
	logic [23:0] mantDiff;
	logic [4:0] lzCount;
	logic [23:0] mantNorm;
	logic signed [9:0] expNorm;

	// an operand with exponent 0 is cleared to a true zero.
	assign aMag = (a[30:23] == 8'd0) ? '0 : a[30:0];
	assign bMag = (b[30:23] == 8'd0) ? '0 : b[30:0];

	assign swap = bMag > aMag;
	assign bigOp = swap ? {b[31], bMag} : {a[31], aMag};
	assign smallOp = swap ? {a[31], aMag} : {b[31], bMag};

	assign expBig = bigOp[30:23];
	assign mantBig = {|bigOp[30:23], bigOp[22:0]};
	assign mantSmall = {|smallOp[30:23], smallOp[22:0]};

	assign shiftAmt = bigOp[30:23] - smallOp[30:23];
	assign mantAligned = (shiftAmt > 8'd23) ? '0 : (mantSmall >> shiftAmt); // truncates.

	assign subtract = bigOp[31] ^ smallOp[31];
	assign mantSum = {1'b0, mantBig} + {1'b0, mantAligned};
	assign mantDiff = mantBig - mantAligned; // never negative, big is ordered first.

	// leading-zero search, the highest set bit wins.
	always_comb
	begin
		lzCount = 5'd0;
		for (int i = 0; i < 24; i++)
			if (mantDiff[i])
				lzCount = 5'(23 - i);
	end

	always_comb
	begin
		if (subtract)
		begin
			mantNorm = mantDiff << lzCount;
			expNorm = $signed({2'b00, expBig}) - $signed({5'b00000, lzCount});
		end
		else if (mantSum[24])
		begin
			mantNorm = mantSum[24:1]; // carry out, lowest bit dropped.
			expNorm = $signed({2'b00, expBig}) + 10'sd1;
		end
		else
		begin
			mantNorm = mantSum[23:0];
			expNorm = $signed({2'b00, expBig});
		end
	end

	always_comb
	begin
		if (mantNorm == 24'd0 || expNorm <= 10'sd0)
			sum = '0; // exact cancellation and underflow give +0.
		else if (expNorm >= 10'sd255)
			sum = {bigOp[31], maxMagnitude};
		else
			sum = {bigOp[31], expNorm[7:0], mantNorm[22:0]};
	end
endmodule

// ==== verilog/floatMult.sv ====
`timescale 1ns/1ps

module floatMult (
	input  logic [fcNeuronPkg::floatWidth-1:0] x,
	input  logic [fcNeuronPkg::floatWidth-1:0] y,
	output logic [fcNeuronPkg::floatWidth-1:0] z
);
	import fcNeuronPkg::*;

	logic zeroIn;
	logic signOut;
	logic [47:0] mantProd;
	logic signed [9:0] expSum;
	logic signed [9:0] expNorm;
	logic [22:0] fracNorm;

	assign zeroIn = (x[30:23] == 8'd0) || (y[30:23] == 8'd0); // exponent 0 counts as zero.
	assign signOut = x[31] ^ y[31];
	assign mantProd = {1'b1, x[22:0]} * {1'b1, y[22:0]};
	assign expSum = $signed({2'b00, x[30:23]}) + $signed({2'b00, y[30:23]}) - floatBias;

	// the product of two 1.x mantissas lies in [1, 4), so one shift at most.
	always_comb
	begin
		if (mantProd[47])
		begin
			fracNorm = mantProd[46:24];
			expNorm = expSum + 10'sd1;
		end
		else
		begin
			fracNorm = mantProd[45:23];
			expNorm = expSum;
		end
	end

	always_comb
	begin
		if (zeroIn || expNorm <= 10'sd0)
			z = '0; // underflow flushes.
		else if (expNorm >= 10'sd255)
			z = {signOut, maxMagnitude}; // saturate, keep sign.
		else
			z = {signOut, expNorm[7:0], fracNorm};
	end
endmodule

// ==== verilog/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode (
	input  logic clk,
	input  logic reset,
	input  fcNeuronPkg::nodeParams params,
	input  logic [fcNeuronPkg::numInputs-1:0][fcNeuronPkg::floatWidth-1:0] activations,
	input  logic inValid,
	output logic [fcNeuronPkg::floatWidth-1:0] result,
	output logic outValid
);
	import fcNeuronPkg::*;

	logic [numInputs-1:0][floatWidth-1:0] products;
	logic [floatWidth-1:0] treeReg [1:2*treeLeaves-1]; // heap order, leaves in the upper half.
	logic [floatWidth-1:0] treeSum [1:treeLeaves-1];
	logic [stageCount-2:0] validPipe;

	genvar k;
	generate
		for (k = 0; k < numInputs; k++)
		begin : multBank
			floatMult mult (
				.x(activations[k]),
				.y(params.weights[k]),
				.z(products[k])
			);
		end

		// node k adds its two children, so 8..15 form the first level.
		for (k = 1; k < treeLeaves; k++)
		begin : addTree
			floatAdder add (
				.a(treeReg[2*k]),
				.b(treeReg[2*k+1]),
				.sum(treeSum[k])
			);
		end
	endgenerate

	// stage one loads the leaves, stages two to five move up one level each.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numInputs; i++)
			treeReg[treeLeaves+i] <= products[i];
		treeReg[2*treeLeaves-1] <= params.bias; // bias pairs with the last product.
		for (int i = 1; i < treeLeaves; i++)
			treeReg[i] <= treeSum[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			validPipe <= {validPipe[stageCount-3:0], inValid};
			outValid <= validPipe[stageCount-2];
		end
	end

	// stage six, relu. holds while nothing valid arrives.
	always_ff @(posedge clk)
	begin
		if (validPipe[stageCount-2])
			result <= treeReg[1][floatWidth-1] ? '0 : treeReg[1]; // -0 also maps to +0.
	end
endmodule

// ==== verilog/neuronRegs.sv ====
`timescale 1ns/1ps

module neuronRegs (
	input  logic clk,
	input  logic reset,
	input  fcNeuronPkg::axiLiteReq bus,
	output fcNeuronPkg::axiLiteResp busResp,
	output fcNeuronPkg::nodeParams params
);
	import fcNeuronPkg::*;

	wrState writeState;
	rdState readState;
	logic wrAccept; // drives both write readies.
	logic rdAccept;
	logic bValid;
	logic rValid;
	axiResp bResp;
	axiResp rResp;
	logic [floatWidth-1:0] rData;
	logic [treeLeaves-1:0][floatWidth-1:0] regWords; // weights, bias in the top word.
	logic wrMapped;
	logic rdMapped;
	logic [regIndexWidth-1:0] wrIndex;
	logic [regIndexWidth-1:0] rdIndex;

	assign wrMapped = bus.awAddr <= biasAddr;
	assign rdMapped = bus.arAddr <= biasAddr;
	assign wrIndex = bus.awAddr[regIndexWidth+1:2];
	assign rdIndex = bus.arAddr[regIndexWidth+1:2];

	// write channel, address and data are taken together.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			writeState <= wrIdle;
			wrAccept <= 1'b0;
			bValid <= 1'b0;
			regWords <= '0;
		end
		else
		begin
			case (writeState)
				wrIdle:
				begin
					if (wrAccept)
					begin
						wrAccept <= 1'b0;
						bValid <= 1'b1;
						writeState <= wrResp;
						if (wrMapped)
						begin
							for (int n = 0; n < floatWidth / 8; n++)
								if (bus.wStrb[n])
									regWords[wrIndex][8*n +: 8] <= bus.wData[8*n +: 8];
						end
					end
					else if (bus.awValid && bus.wValid)
						wrAccept <= 1'b1;
				end
				wrResp:
				begin
					if (bus.bReady)
					begin
						bValid <= 1'b0;
						writeState <= wrIdle;
					end
				end
				default: writeState <= wrIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readState <= rdIdle;
			rdAccept <= 1'b0;
			rValid <= 1'b0;
		end
		else
		begin
			case (readState)
				rdIdle:
				begin
					if (rdAccept)
					begin
						rdAccept <= 1'b0;
						rValid <= 1'b1;
						readState <= rdData;
					end
					else if (bus.arValid)
						rdAccept <= 1'b1;
				end
				rdData:
				begin
					if (bus.rReady)
					begin
						rValid <= 1'b0;
						readState <= rdIdle;
					end
				end
				default: readState <= rdIdle;
			endcase
		end
	end

	// response payload, captured on the accepting cycle.
	always_ff @(posedge clk)
	begin
		if (wrAccept)
		begin
			if (wrMapped)
				bResp <= OKAY;
			else
				bResp <= SLVERR;
		end
		if (rdAccept)
		begin
			if (rdMapped)
			begin
				rData <= regWords[rdIndex];
				rResp <= OKAY;
			end
			else
			begin
				rData <= '0;
				rResp <= SLVERR;
			end
		end
	end

	assign busResp = '{
		awReady: wrAccept,
		wReady: wrAccept,
		arReady: rdAccept,
		bValid: bValid,
		bResp: bResp,
		rData: rData,
		rValid: rValid,
		rResp: rResp
	};

	assign params = '{weights: regWords[numInputs-1:0], bias: regWords[numInputs]};
endmodule
